//--- src/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // exact instruction, one value per kept RV32I instruction
    typedef enum logic [5:0] {
        OP_NONE,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI,
        OP_SRLI, OP_SRAI, OP_ORI, OP_ANDI,
        OP_AUIPC,
        OP_SB, OP_SH, OP_SW,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_LUI,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JALR, OP_JAL,
        OP_FENCE, OP_FENCE_I,
        OP_ILLEGAL
    } instr_op_e;

    typedef enum logic [3:0] {
        GRP_LOAD,
        GRP_STORE,
        GRP_OP_IMM,
        GRP_OP_REG,
        GRP_LUI,
        GRP_AUIPC,
        GRP_BRANCH,
        GRP_JAL,
        GRP_JALR,
        GRP_MISC_MEM,
        GRP_NONE
    } instr_grp_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE
    } imm_fmt_e;

    // bit 4 set only for arithmetic right shift
    typedef enum logic [4:0] {
        ALU_EQ   = 5'b0_0000,
        ALU_LTS  = 5'b0_0001,
        ALU_LTU  = 5'b0_0010,
        ALU_NEQ  = 5'b0_0011,
        ALU_NLTS = 5'b0_0100,
        ALU_NLTU = 5'b0_0101,
        ALU_ADD  = 5'b0_0110,
        ALU_SUB  = 5'b0_0111,
        ALU_XOR  = 5'b0_1000,
        ALU_OR   = 5'b0_1001,
        ALU_AND  = 5'b0_1010,
        ALU_SHL  = 5'b0_1011,
        ALU_SHR  = 5'b0_1100,
        ALU_SRA  = 5'b1_1100
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        RES_ALU    = 2'd0,
        RES_MEMORY = 2'd1,
        RES_PC_P4  = 2'd2
    } res_src_e;

    typedef enum logic {
        OP1_REG = 1'b0,
        OP1_PC  = 1'b1
    } op1_sel_e;

    typedef enum logic {
        OP2_REG = 1'b0,
        OP2_IMM = 1'b1
    } op2_sel_e;

endpackage

//--- src/rv_class_if.sv
`timescale 1ns/100ps

interface rv_class_if;
    import rv_decode_pkg::*;

    instr_op_e  op;
    instr_grp_e grp;
    imm_fmt_e   fmt;
    logic       supported;

    modport producer
    (
        output op, grp, fmt, supported
    );

    // operand side needs the lui check and the immediate format
    modport operand
    (
        input op, fmt
    );

    modport ctrl
    (
        input op, grp, supported
    );

endinterface

//--- src/rv_instr_class.sv
`timescale 1ns/100ps

module rv_instr_class
(
    input   logic [rv_decode_pkg::XLEN-1:0] i_instr,
    rv_class_if.producer                    cls
);
    import rv_decode_pkg::*;

    localparam logic [4:0] OPC_LOAD     = 5'b00000;
    localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
    localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
    localparam logic [4:0] OPC_AUIPC    = 5'b00101;
    localparam logic [4:0] OPC_STORE    = 5'b01000;
    localparam logic [4:0] OPC_OP_REG   = 5'b01100;
    localparam logic [4:0] OPC_LUI      = 5'b01101;
    localparam logic [4:0] OPC_BRANCH   = 5'b11000;
    localparam logic [4:0] OPC_JALR     = 5'b11001;
    localparam logic [4:0] OPC_JAL      = 5'b11011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       full;
    instr_grp_e grp;
    instr_op_e  op;
    imm_fmt_e   fmt;

    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    // compressed encodings have low bits other than 11
    assign full   = (i_instr[1:0] == 2'b11);

    always_comb
    begin
        grp = GRP_NONE;
        if (full)
        begin
            case (i_instr[6:2])
                OPC_LOAD:     grp = GRP_LOAD;
                OPC_MISC_MEM: grp = GRP_MISC_MEM;
                OPC_OP_IMM:   grp = GRP_OP_IMM;
                OPC_AUIPC:    grp = GRP_AUIPC;
                OPC_STORE:    grp = GRP_STORE;
                OPC_OP_REG:   grp = GRP_OP_REG;
                OPC_LUI:      grp = GRP_LUI;
                OPC_BRANCH:   grp = GRP_BRANCH;
                OPC_JALR:     grp = GRP_JALR;
                OPC_JAL:      grp = GRP_JAL;
                // system group and unknown opcodes
                default:      grp = GRP_NONE;
            endcase
        end
    end

    always_comb
    begin
        op = OP_ILLEGAL;
        case (grp)
            GRP_LOAD:
            begin
                case (funct3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            GRP_OP_IMM:
            begin
                case (funct3)
                    3'b000:  op = OP_ADDI;
                    3'b001:  op = OP_SLLI;
                    3'b010:  op = OP_SLTI;
                    3'b011:  op = OP_SLTIU;
                    3'b100:  op = OP_XORI;
                    3'b101:  op = (funct7 == F7_BASE) ? OP_SRLI :
                                  (funct7 == F7_ALT)  ? OP_SRAI : OP_ILLEGAL;
                    3'b110:  op = OP_ORI;
                    default: op = OP_ANDI;
                endcase
            end
            GRP_OP_REG:
            begin
                if (funct7 == F7_BASE)
                begin
                    case (funct3)
                        3'b000:  op = OP_ADD;
                        3'b001:  op = OP_SLL;
                        3'b010:  op = OP_SLT;
                        3'b011:  op = OP_SLTU;
                        3'b100:  op = OP_XOR;
                        3'b101:  op = OP_SRL;
                        3'b110:  op = OP_OR;
                        default: op = OP_AND;
                    endcase
                end
                else if (funct7 == F7_ALT)
                begin
                    if (funct3 == 3'b000)
                        op = OP_SUB;
                    else if (funct3 == 3'b101)
                        op = OP_SRA;
                end
            end
            GRP_STORE:
            begin
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    default: op = OP_ILLEGAL;
                endcase
            end
            GRP_BRANCH:
            begin
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            GRP_MISC_MEM:
            begin
                if (funct3 == 3'b000)
                    op = OP_FENCE;
                else if (funct3 == 3'b001)
                    op = OP_FENCE_I;
            end
            GRP_LUI:   op = OP_LUI;
            GRP_AUIPC: op = OP_AUIPC;
            GRP_JAL:   op = OP_JAL;
            GRP_JALR:  op = (funct3 == 3'b000) ? OP_JALR : OP_ILLEGAL;
            // all-zero word is a valid no-op
            default:   op = (i_instr == '0) ? OP_NONE : OP_ILLEGAL;
        endcase
    end

    always_comb
    begin
        case (grp)
            GRP_LOAD, GRP_OP_IMM, GRP_JALR: fmt = IMM_I;
            GRP_STORE:                      fmt = IMM_S;
            GRP_BRANCH:                     fmt = IMM_B;
            GRP_LUI, GRP_AUIPC:             fmt = IMM_U;
            GRP_JAL:                        fmt = IMM_J;
            default:                        fmt = IMM_NONE;
        endcase
        if (op == OP_ILLEGAL)
            fmt = IMM_NONE;
    end

    assign cls.op        = op;
    assign cls.grp       = grp;
    assign cls.fmt       = fmt;
    assign cls.supported = (op != OP_ILLEGAL);

endmodule

//--- src/rv_operand_gen.sv
`timescale 1ns/100ps

module rv_operand_gen
(
    input   logic                                   i_clk,
    input   logic                                   i_arst_n,
    input   logic [rv_decode_pkg::XLEN-1:0]         i_instr,
    rv_class_if.operand                             cls,
    output  logic [rv_decode_pkg::REG_IDX_W-1:0]    o_rs1,
    output  logic [rv_decode_pkg::REG_IDX_W-1:0]    o_rs2,
    output  logic [rv_decode_pkg::REG_IDX_W-1:0]    o_rd,
    output  logic [2:0]                             o_funct3,
    output  logic [rv_decode_pkg::XLEN-1:0]         o_imm
);
    import rv_decode_pkg::*;

    logic [REG_IDX_W-1:0]   rs1;
    logic [XLEN-1:0]        imm;

    // lui reads x0 so the alu adds the immediate to zero
    assign rs1 = (cls.op == OP_LUI) ? '0 : i_instr[19:15];

    always_comb
    begin
        case (cls.fmt)
            IMM_I:
                imm = {{20{i_instr[31]}}, i_instr[31:20]};
            IMM_S:
                imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            IMM_B:
                imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                       i_instr[30:25], i_instr[11:8], 1'b0};
            IMM_U:
                imm = {i_instr[31:12], 12'b0};
            IMM_J:
                imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                       i_instr[20], i_instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_rs1    <= '0;
            o_rs2    <= '0;
            o_rd     <= '0;
            o_funct3 <= '0;
            o_imm    <= '0;
        end
        else
        begin
            o_rs1    <= rs1;
            o_rs2    <= i_instr[24:20];
            o_rd     <= i_instr[11:7];
            o_funct3 <= i_instr[14:12];
            o_imm    <= imm;
        end
    end

endmodule

//--- src/rv_ctrl_gen.sv
`timescale 1ns/100ps

module rv_ctrl_gen
(
    input   logic                       i_clk,
    input   logic                       i_arst_n,
    input   logic                       i_flush,
    rv_class_if.ctrl                    cls,
    output  logic                       o_reg_write,
    output  logic                       o_mem_read,
    output  logic                       o_mem_write,
    output  logic                       o_jump,
    output  logic                       o_branch,
    output  logic                       o_pc_sel,
    output  logic                       o_inv_instr,
    output  rv_decode_pkg::res_src_e    o_res_src,
    output  rv_decode_pkg::op1_sel_e    o_alu_op1_sel,
    output  rv_decode_pkg::op2_sel_e    o_alu_op2_sel,
    output  rv_decode_pkg::alu_ctrl_e   o_alu_ctrl
);
    import rv_decode_pkg::*;

    instr_grp_e grp;
    logic       reg_write;
    res_src_e   res_src;
    op1_sel_e   op1_sel;
    op2_sel_e   op2_sel;
    alu_ctrl_e  alu_ctrl;

    // rejected words drive no datapath control
    assign grp = cls.supported ? cls.grp : GRP_NONE;

    assign reg_write = grp inside {GRP_LOAD, GRP_OP_IMM, GRP_OP_REG, GRP_LUI,
                                   GRP_AUIPC, GRP_JAL, GRP_JALR};

    assign op1_sel = (grp inside {GRP_AUIPC, GRP_JAL}) ? OP1_PC : OP1_REG;
    assign op2_sel = (grp inside {GRP_AUIPC, GRP_JAL, GRP_JALR, GRP_LUI,
                                  GRP_OP_IMM, GRP_LOAD, GRP_STORE}) ? OP2_IMM : OP2_REG;

    always_comb
    begin
        case (grp)
            GRP_LOAD:          res_src = RES_MEMORY;
            GRP_JAL, GRP_JALR: res_src = RES_PC_P4;
            default:           res_src = RES_ALU;
        endcase
    end

    // branches reuse the comparator codes, address math falls to add
    always_comb
    begin
        case (cls.op)
            OP_BEQ:                     alu_ctrl = ALU_EQ;
            OP_SLTI, OP_SLT, OP_BLT:    alu_ctrl = ALU_LTS;
            OP_SLTIU, OP_SLTU, OP_BLTU: alu_ctrl = ALU_LTU;
            OP_BNE:                     alu_ctrl = ALU_NEQ;
            OP_BGE:                     alu_ctrl = ALU_NLTS;
            OP_BGEU:                    alu_ctrl = ALU_NLTU;
            OP_SUB:                     alu_ctrl = ALU_SUB;
            OP_XORI, OP_XOR:            alu_ctrl = ALU_XOR;
            OP_ORI, OP_OR:              alu_ctrl = ALU_OR;
            OP_ANDI, OP_AND:            alu_ctrl = ALU_AND;
            OP_SLLI, OP_SLL:            alu_ctrl = ALU_SHL;
            OP_SRLI, OP_SRL:            alu_ctrl = ALU_SHR;
            OP_SRAI, OP_SRA:            alu_ctrl = ALU_SRA;
            default:                    alu_ctrl = ALU_ADD;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_reg_write   <= 1'b0;
            o_mem_read    <= 1'b0;
            o_mem_write   <= 1'b0;
            o_jump        <= 1'b0;
            o_branch      <= 1'b0;
            o_pc_sel      <= 1'b0;
            o_inv_instr   <= 1'b0;
            o_res_src     <= RES_ALU;
            o_alu_op1_sel <= OP1_REG;
            o_alu_op2_sel <= OP2_REG;
            o_alu_ctrl    <= ALU_ADD;
        end
        else
        begin
            // flush leaves a bubble with every flag cleared
            o_reg_write   <= !i_flush && reg_write;
            o_mem_read    <= !i_flush && (grp == GRP_LOAD);
            o_mem_write   <= !i_flush && (grp == GRP_STORE);
            o_jump        <= !i_flush && (grp inside {GRP_JAL, GRP_JALR});
            o_branch      <= !i_flush && (grp == GRP_BRANCH);
            o_pc_sel      <= !i_flush && (grp == GRP_JALR);
            o_inv_instr   <= !i_flush && !cls.supported;
            o_res_src     <= i_flush ? RES_ALU : res_src;
            o_alu_op1_sel <= i_flush ? OP1_REG : op1_sel;
            o_alu_op2_sel <= i_flush ? OP2_REG : op2_sel;
            o_alu_ctrl    <= i_flush ? ALU_ADD : alu_ctrl;
        end
    end

endmodule

//--- src/rv_decode_stage.sv
`timescale 1ns/100ps

module rv_decode_stage
(
    input   logic                                   i_clk,
    input   logic                                   i_arst_n,
    input   logic                                   i_flush,
    input   logic [rv_decode_pkg::XLEN-1:0]         i_instr,
    output  logic [rv_decode_pkg::REG_IDX_W-1:0]    o_rs1,
    output  logic [rv_decode_pkg::REG_IDX_W-1:0]    o_rs2,
    output  logic [rv_decode_pkg::REG_IDX_W-1:0]    o_rd,
    output  logic [2:0]                             o_funct3,
    output  logic [rv_decode_pkg::XLEN-1:0]         o_imm,
    output  logic                                   o_reg_write,
    output  logic                                   o_mem_read,
    output  logic                                   o_mem_write,
    output  logic                                   o_jump,
    output  logic                                   o_branch,
    output  logic                                   o_pc_sel,
    output  logic                                   o_inv_instr,
    output  rv_decode_pkg::res_src_e                o_res_src,
    output  rv_decode_pkg::op1_sel_e                o_alu_op1_sel,
    output  rv_decode_pkg::op2_sel_e                o_alu_op2_sel,
    output  rv_decode_pkg::alu_ctrl_e               o_alu_ctrl
);

    // classification is combinational, both consumers register it
    rv_class_if u_cls ();

    rv_instr_class u_class
    (
        .i_instr        (i_instr),
        .cls            (u_cls.producer)
    );

    rv_operand_gen u_operand
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_instr        (i_instr),
        .cls            (u_cls.operand),
        .o_rs1          (o_rs1),
        .o_rs2          (o_rs2),
        .o_rd           (o_rd),
        .o_funct3       (o_funct3),
        .o_imm          (o_imm)
    );

    rv_ctrl_gen u_ctrl
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_flush        (i_flush),
        .cls            (u_cls.ctrl),
        .o_reg_write    (o_reg_write),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_jump         (o_jump),
        .o_branch       (o_branch),
        .o_pc_sel       (o_pc_sel),
        .o_inv_instr    (o_inv_instr),
        .o_res_src      (o_res_src),
        .o_alu_op1_sel  (o_alu_op1_sel),
        .o_alu_op2_sel  (o_alu_op2_sel),
        .o_alu_ctrl     (o_alu_ctrl)
    );

endmodule

//--- sim/tb_rv_decode_stage.sv
`timescale 1ns/100ps

module tb_rv_decode_stage;
    import rv_decode_pkg::*;

    localparam int RST_TIMEOUT = 20;

    // flag order: reg_write mem_read mem_write jump branch pc_sel inv_instr
    localparam logic [6:0] FL_NONE = 7'b0000000;
    localparam logic [6:0] FL_RW   = 7'b1000000;
    localparam logic [6:0] FL_MR   = 7'b0100000;
    localparam logic [6:0] FL_MW   = 7'b0010000;
    localparam logic [6:0] FL_JMP  = 7'b0001000;
    localparam logic [6:0] FL_BR   = 7'b0000100;
    localparam logic [6:0] FL_PC   = 7'b0000010;
    localparam logic [6:0] FL_INV  = 7'b0000001;

    typedef struct packed {
        logic [XLEN-1:0]      instr;
        logic                 flush;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rd;
        logic [2:0]           funct3;
        logic [XLEN-1:0]      imm;
        alu_ctrl_e            alu;
        op1_sel_e             op1;
        op2_sel_e             op2;
        res_src_e             res;
        logic [6:0]           flags;
    } row_t;

    logic                 i_clk;
    logic                 i_arst_n;
    logic                 i_flush;
    logic [XLEN-1:0]      i_instr;
    logic [REG_IDX_W-1:0] o_rs1;
    logic [REG_IDX_W-1:0] o_rs2;
    logic [REG_IDX_W-1:0] o_rd;
    logic [2:0]           o_funct3;
    logic [XLEN-1:0]      o_imm;
    logic                 o_reg_write;
    logic                 o_mem_read;
    logic                 o_mem_write;
    logic                 o_jump;
    logic                 o_branch;
    logic                 o_pc_sel;
    logic                 o_inv_instr;
    res_src_e             o_res_src;
    op1_sel_e             o_alu_op1_sel;
    op2_sel_e             o_alu_op2_sel;
    alu_ctrl_e            o_alu_ctrl;

    row_t rows[$];

    rv_decode_stage i_dut
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_flush        (i_flush),
        .i_instr        (i_instr),
        .o_rs1          (o_rs1),
        .o_rs2          (o_rs2),
        .o_rd           (o_rd),
        .o_funct3       (o_funct3),
        .o_imm          (o_imm),
        .o_reg_write    (o_reg_write),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_jump         (o_jump),
        .o_branch       (o_branch),
        .o_pc_sel       (o_pc_sel),
        .o_inv_instr    (o_inv_instr),
        .o_res_src      (o_res_src),
        .o_alu_op1_sel  (o_alu_op1_sel),
        .o_alu_op2_sel  (o_alu_op2_sel),
        .o_alu_ctrl     (o_alu_ctrl)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    initial
    begin
        i_arst_n = 1'b0;
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_arst_n = 1'b1;
    end

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "decode stage check stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp)
        begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, act, exp);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] act,
                              input logic [XLEN-1:0] exp);
        if (act !== exp)
        begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, act, exp);
            stop_run();
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_IDX_W-1:0] act,
                             input logic [REG_IDX_W-1:0] exp);
        if (act !== exp)
        begin
            $display("Fail at %0t: %s is x%0d, expected x%0d", $time, name, act, exp);
            stop_run();
        end
    endtask

    task automatic check_funct3(input string name, input logic [2:0] act,
                                input logic [2:0] exp);
        if (act !== exp)
        begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, act, exp);
            stop_run();
        end
    endtask

    task automatic check_alu(input string name, input alu_ctrl_e act, input alu_ctrl_e exp);
        if (act !== exp)
        begin
            $display("Fail at %0t: %s is %s, expected %s", $time, name, act.name(), exp.name());
            stop_run();
        end
    endtask

    task automatic check_res(input string name, input res_src_e act, input res_src_e exp);
        if (act !== exp)
        begin
            $display("Fail at %0t: %s is %s, expected %s", $time, name, act.name(), exp.name());
            stop_run();
        end
    endtask

    task automatic check_op1(input string name, input op1_sel_e act, input op1_sel_e exp);
        if (act !== exp)
        begin
            $display("Fail at %0t: %s is %s, expected %s", $time, name, act.name(), exp.name());
            stop_run();
        end
    endtask

    task automatic check_op2(input string name, input op2_sel_e act, input op2_sel_e exp);
        if (act !== exp)
        begin
            $display("Fail at %0t: %s is %s, expected %s", $time, name, act.name(), exp.name());
            stop_run();
        end
    endtask

    task automatic check_row(input row_t r);
        check_reg("o_rs1", o_rs1, r.rs1);
        check_reg("o_rs2", o_rs2, r.rs2);
        check_reg("o_rd", o_rd, r.rd);
        check_funct3("o_funct3", o_funct3, r.funct3);
        check_word("o_imm", o_imm, r.imm);
        check_alu("o_alu_ctrl", o_alu_ctrl, r.alu);
        check_op1("o_alu_op1_sel", o_alu_op1_sel, r.op1);
        check_op2("o_alu_op2_sel", o_alu_op2_sel, r.op2);
        check_res("o_res_src", o_res_src, r.res);
        check_bit("o_reg_write", o_reg_write, r.flags[6]);
        check_bit("o_mem_read", o_mem_read, r.flags[5]);
        check_bit("o_mem_write", o_mem_write, r.flags[4]);
        check_bit("o_jump", o_jump, r.flags[3]);
        check_bit("o_branch", o_branch, r.flags[2]);
        check_bit("o_pc_sel", o_pc_sel, r.flags[1]);
        check_bit("o_inv_instr", o_inv_instr, r.flags[0]);
    endtask

    // register fields come straight from the word, lui reads x0
    task automatic push_row(input logic [XLEN-1:0] instr, input logic [XLEN-1:0] imm,
                            input alu_ctrl_e alu, input op1_sel_e op1, input op2_sel_e op2,
                            input res_src_e res, input logic [6:0] flags, input logic is_lui);
        row_t r;
        r.instr  = instr;
        r.flush  = 1'b0;
        r.rs1    = is_lui ? '0 : instr[19:15];
        r.rs2    = instr[24:20];
        r.rd     = instr[11:7];
        r.funct3 = instr[14:12];
        r.imm    = imm;
        r.alu    = alu;
        r.op1    = op1;
        r.op2    = op2;
        r.res    = res;
        r.flags  = flags;
        rows.push_back(r);
    endtask

    task automatic add_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2, input alu_ctrl_e alu,
                         input logic [6:0] flags);
        push_row({f7, rs2, rs1, f3, rd, 7'b0110011}, '0, alu, OP1_REG, OP2_REG, RES_ALU,
                 flags, 1'b0);
    endtask

    task automatic add_i(input logic [6:0] opc, input logic [2:0] f3, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [11:0] imm, input alu_ctrl_e alu,
                         input res_src_e res, input logic [6:0] flags);
        push_row({imm, rs1, f3, rd, opc}, {{20{imm[11]}}, imm}, alu, OP1_REG, OP2_IMM, res,
                 flags, 1'b0);
    endtask

    task automatic add_s(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic [11:0] imm);
        push_row({imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011}, {{20{imm[11]}}, imm},
                 ALU_ADD, OP1_REG, OP2_IMM, RES_ALU, FL_MW, 1'b0);
    endtask

    // offset bit 0 is always zero
    task automatic add_b(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic [12:0] imm, input alu_ctrl_e alu);
        push_row({imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011},
                 {{19{imm[12]}}, imm}, alu, OP1_REG, OP2_REG, RES_ALU, FL_BR, 1'b0);
    endtask

    task automatic add_u(input logic [6:0] opc, input logic [4:0] rd, input logic [19:0] imm,
                         input op1_sel_e op1, input logic is_lui);
        push_row({imm, rd, opc}, {imm, 12'b0}, ALU_ADD, op1, OP2_IMM, RES_ALU, FL_RW, is_lui);
    endtask

    task automatic add_j(input logic [4:0] rd, input logic [20:0] imm);
        push_row({imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111},
                 {{11{imm[20]}}, imm}, ALU_ADD, OP1_PC, OP2_IMM, RES_PC_P4, FL_RW | FL_JMP, 1'b0);
    endtask

    task automatic add_raw(input logic [XLEN-1:0] instr, input logic [6:0] flags);
        push_row(instr, '0, ALU_ADD, OP1_REG, OP2_REG, RES_ALU, flags, 1'b0);
    endtask

    // repeats the last row as a bubble, operands kept and every control dropped
    task automatic push_flushed_copy();
        row_t r;
        r       = rows[$];
        r.flush = 1'b1;
        r.alu   = ALU_ADD;
        r.op1   = OP1_REG;
        r.op2   = OP2_REG;
        r.res   = RES_ALU;
        r.flags = FL_NONE;
        rows.push_back(r);
    endtask

    task automatic build_table();
        int             seed;
        logic [4:0]     rd;
        logic [4:0]     rs1;
        logic [4:0]     rs2;
        seed = 13;
        add_i(7'b0010011, 3'b000, 5'd5, 5'd3, 12'hFEC, ALU_ADD, RES_ALU, FL_RW);
        add_i(7'b0010011, 3'b010, 5'd6, 5'd4, 12'h7FF, ALU_LTS, RES_ALU, FL_RW);
        add_i(7'b0010011, 3'b011, 5'd7, 5'd8, 12'h800, ALU_LTU, RES_ALU, FL_RW);
        add_i(7'b0010011, 3'b100, 5'd9, 5'd10, 12'hABC, ALU_XOR, RES_ALU, FL_RW);
        add_i(7'b0010011, 3'b110, 5'd11, 5'd12, 12'h123, ALU_OR, RES_ALU, FL_RW);
        add_i(7'b0010011, 3'b111, 5'd13, 5'd14, 12'hF0F, ALU_AND, RES_ALU, FL_RW);
        add_i(7'b0010011, 3'b001, 5'd15, 5'd16, {7'b0000000, 5'd7}, ALU_SHL, RES_ALU, FL_RW);
        add_i(7'b0010011, 3'b101, 5'd17, 5'd18, {7'b0000000, 5'd31}, ALU_SHR, RES_ALU, FL_RW);
        add_i(7'b0010011, 3'b101, 5'd19, 5'd20, {7'b0100000, 5'd4}, ALU_SRA, RES_ALU, FL_RW);
        push_flushed_copy();
        add_r(7'b0000000, 3'b000, 5'd1, 5'd2, 5'd3, ALU_ADD, FL_RW);
        add_r(7'b0100000, 3'b000, 5'd4, 5'd5, 5'd6, ALU_SUB, FL_RW);
        add_r(7'b0000000, 3'b001, 5'd7, 5'd8, 5'd9, ALU_SHL, FL_RW);
        add_r(7'b0000000, 3'b010, 5'd10, 5'd11, 5'd12, ALU_LTS, FL_RW);
        add_r(7'b0000000, 3'b011, 5'd13, 5'd14, 5'd15, ALU_LTU, FL_RW);
        add_r(7'b0000000, 3'b100, 5'd16, 5'd17, 5'd18, ALU_XOR, FL_RW);
        add_r(7'b0000000, 3'b101, 5'd19, 5'd20, 5'd21, ALU_SHR, FL_RW);
        add_r(7'b0100000, 3'b101, 5'd22, 5'd23, 5'd24, ALU_SRA, FL_RW);
        add_r(7'b0000000, 3'b110, 5'd25, 5'd26, 5'd27, ALU_OR, FL_RW);
        add_r(7'b0000000, 3'b111, 5'd28, 5'd29, 5'd30, ALU_AND, FL_RW);
        add_r(7'b0000001, 3'b000, 5'd31, 5'd1, 5'd2, ALU_ADD, FL_INV);
        for (int k = 0; k < 4; k++)
        begin
            rd  = 5'($random(seed));
            rs1 = 5'($random(seed));
            rs2 = 5'($random(seed));
            add_r(7'b0000000, 3'b000, rd, rs1, rs2, ALU_ADD, FL_RW);
        end
        add_i(7'b0000011, 3'b000, 5'd1, 5'd2, 12'h004, ALU_ADD, RES_MEMORY, FL_RW | FL_MR);
        add_i(7'b0000011, 3'b001, 5'd3, 5'd4, 12'hFFE, ALU_ADD, RES_MEMORY, FL_RW | FL_MR);
        add_i(7'b0000011, 3'b010, 5'd5, 5'd6, 12'h7FC, ALU_ADD, RES_MEMORY, FL_RW | FL_MR);
        add_i(7'b0000011, 3'b100, 5'd7, 5'd8, 12'h801, ALU_ADD, RES_MEMORY, FL_RW | FL_MR);
        add_i(7'b0000011, 3'b101, 5'd9, 5'd10, 12'h0AA, ALU_ADD, RES_MEMORY, FL_RW | FL_MR);
        add_s(3'b000, 5'd11, 5'd12, 12'h7F5);
        add_s(3'b001, 5'd13, 5'd14, 12'h804);
        add_s(3'b010, 5'd15, 5'd16, 12'h010);
        push_flushed_copy();
        add_b(3'b000, 5'd1, 5'd2, 13'h0010, ALU_EQ);
        add_b(3'b001, 5'd3, 5'd4, 13'h1FF0, ALU_NEQ);
        add_b(3'b100, 5'd5, 5'd6, 13'h0FFE, ALU_LTS);
        add_b(3'b101, 5'd7, 5'd8, 13'h1000, ALU_NLTS);
        add_b(3'b110, 5'd9, 5'd10, 13'h0802, ALU_LTU);
        add_b(3'b111, 5'd11, 5'd12, 13'h07FE, ALU_NLTU);
        add_j(5'd1, 21'h0ABCDE);
        add_j(5'd5, 21'h1FFFFC);
        push_flushed_copy();
        add_i(7'b1100111, 3'b000, 5'd1, 5'd6, 12'hFFC, ALU_ADD, RES_PC_P4,
              FL_RW | FL_JMP | FL_PC);
        add_u(7'b0110111, 5'd2, 20'hDEADB, OP1_REG, 1'b1);
        add_u(7'b0010111, 5'd3, 20'h12345, OP1_PC, 1'b0);
        add_raw(32'h0000_0000, FL_NONE);
        add_raw(32'h0FF0_000F, FL_NONE);
        add_raw(32'h0000_100F, FL_NONE);
        add_raw(32'h0000_4501, FL_INV);
        add_raw(32'h0000_0073, FL_INV);
        add_raw(32'h0010_0073, FL_INV);
        add_raw(32'h0000_0057, FL_INV);
        push_flushed_copy();
    endtask

    task automatic check_idle();
        row_t r;
        r     = '0;
        r.alu = ALU_ADD;
        check_row(r);
    endtask

    initial
    begin
        int cycles;
        // a live word during reset must not reach the outputs
        i_instr = 32'hFFFF_FFFF;
        i_flush = 1'b0;
        build_table();
        @(negedge i_clk);
        check_idle();
        cycles = 0;
        while (i_arst_n !== 1'b1 && cycles < RST_TIMEOUT)
        begin
            @(posedge i_clk);
            cycles++;
        end
        if (i_arst_n !== 1'b1)
        begin
            $display("reset was not released within %0d cycles", RST_TIMEOUT);
            stop_run();
        end
        // each row is checked one cycle after it was driven
        for (int i = 0; i <= rows.size(); i++)
        begin
            @(negedge i_clk);
            if (i > 0)
                check_row(rows[i-1]);
            if (i < rows.size())
            begin
                i_instr = rows[i].instr;
                i_flush = rows[i].flush;
            end
            else
            begin
                i_instr = '0;
                i_flush = 1'b0;
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

//--- rv_decode_stage.f
src/rv_decode_pkg.sv
src/rv_class_if.sv
src/rv_instr_class.sv
src/rv_operand_gen.sv
src/rv_ctrl_gen.sv
src/rv_decode_stage.sv
sim/tb_rv_decode_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_decode_stage
FILELIST  ?= rv_decode_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
